// ==== Makefile ====
TOP = tb_alu

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

obj_dir/V$(TOP): sim.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f sim.f
	verilator --lint-only -Wall --top-module alu_top alu_flag_pkg.sv alu_op_pkg.sv \
	  alu_stage_if.sv cond_eval.sv add_sub_unit.sv logic_move_unit.sv flag_gen.sv alu_top.sv

clean:
	rm -rf obj_dir

// ==== add_sub_unit.sv ====
/*
  64-bit adder-subtractor of the execute cycle.
  Subtract is a + ~b + 1. The chain is cut at bits 3, 7, 15 and 31 so
  every carry and signed overflow tap comes out at once, and the retire
  stage only has to pick the one for the op width.
*/
`default_nettype none

module add_sub_unit import alu_op_pkg::*, alu_flag_pkg::*; (
  input  op_word_t    op,
  input  data_t       a,
  input  data_t       b,
  alu_stage_if.arith  stage
);

  logic        sub;
  data_t       b_eff;
  data_t       sum;
  carry_taps_t cy;

  assign sub   = op_is_sub(op);
  assign b_eff = sub ? ~b : b;

  // segmented carry chain
  assign {cy[0], sum[3:0]}   = {1'b0, a[3:0]} + {1'b0, b_eff[3:0]} + {4'b0, sub};
  assign {cy[1], sum[7:4]}   = {1'b0, a[7:4]} + {1'b0, b_eff[7:4]} + {4'b0, cy[0]};
  assign {cy[2], sum[15:8]}  = {1'b0, a[15:8]} + {1'b0, b_eff[15:8]} + {8'b0, cy[1]};
  assign {cy[3], sum[31:16]} = {1'b0, a[31:16]} + {1'b0, b_eff[31:16]} + {16'b0, cy[2]};
  assign {cy[4], sum[63:32]} = {1'b0, a[63:32]} + {1'b0, b_eff[63:32]} + {32'b0, cy[3]};

  assign stage.sum        = sum;
  assign stage.carry_taps = cy;

  // overflow when both addends share a sign the sum lacks
  assign stage.ovf_taps[0] = (a[7] == (b[7] ^ sub)) && (sum[7] != a[7]);
  assign stage.ovf_taps[1] = (a[15] == (b[15] ^ sub)) && (sum[15] != a[15]);
  assign stage.ovf_taps[2] = (a[31] == (b[31] ^ sub)) && (sum[31] != a[31]);
  assign stage.ovf_taps[3] = (a[63] == (b[63] ^ sub)) && (sum[63] != a[63]);

endmodule

`default_nettype wire

// ==== alu_flag_pkg.sv ====
/*
  Result side definitions for the integer ALU.
  Flag word layout, the carry and signed overflow tap words that the
  adder hands to the retire stage, and the 64-bit data word.
*/
`default_nettype none

package alu_flag_pkg;

  typedef logic [63:0] data_t;

  // flag word, C at the top down to P at bit 0
  typedef logic [5:0] flags_t;

  localparam int flag_c = 5;
  localparam int flag_o = 4;
  localparam int flag_a = 3;
  localparam int flag_s = 2;
  localparam int flag_z = 1;
  localparam int flag_p = 0;

  // carry out of bit 3, 7, 15, 31, 63 in index order
  typedef logic [4:0] carry_taps_t;

  // signed overflow at 8, 16, 32, 64 bits, indexed by width code
  typedef logic [3:0] ovf_taps_t;

endpackage

`default_nettype wire

// ==== alu_op_pkg.sv ====
/*
  Instruction side definitions for the integer ALU.
  Holds the operation word with its plain and conditional views, the
  8-bit opcode map, the condition codes and the decode helpers that
  the execute units and the retire stage share.
*/
`default_nettype none

package alu_op_pkg;

  // one 13-bit word, read through one of two views
  typedef union packed {
    struct packed {
      logic       no_flags;
      logic       reserved;
      logic [2:0] modifier;
      logic [7:0] code;
    } plain;
    struct packed {
      logic       no_flags;
      logic       reserved;
      logic [2:0] cond_sel;
      logic [6:0] code_hi;
      logic       invert;
    } cond;
  } op_word_t;

  typedef logic [3:0] cond_t; // {cond_sel, invert}

  typedef enum logic [2:0] {arith, logic_op, move, cond_op, lahf, illegal} op_class_t;

  // width codes, also the index of the overflow tap
  localparam logic [1:0] width_8  = 2'd0;
  localparam logic [1:0] width_16 = 2'd1;
  localparam logic [1:0] width_32 = 2'd2;
  localparam logic [1:0] width_64 = 2'd3;

  localparam logic [7:0] op_add64  = 8'h00;
  localparam logic [7:0] op_sub64  = 8'h01;
  localparam logic [7:0] op_add32  = 8'h02;
  localparam logic [7:0] op_sub32  = 8'h03;
  localparam logic [7:0] op_cmp16  = 8'h04;
  localparam logic [7:0] op_cmp8   = 8'h05;
  localparam logic [7:0] op_and64  = 8'h08;
  localparam logic [7:0] op_and32  = 8'h09;
  localparam logic [7:0] op_or64   = 8'h0a;
  localparam logic [7:0] op_or32   = 8'h0b;
  localparam logic [7:0] op_xor64  = 8'h0c;
  localparam logic [7:0] op_xor32  = 8'h0d;
  localparam logic [7:0] op_xnor64 = 8'h0e;
  localparam logic [7:0] op_xnor32 = 8'h0f;
  localparam logic [7:0] op_mov64  = 8'h10;
  localparam logic [7:0] op_mov32  = 8'h11;
  localparam logic [7:0] op_zxt8   = 8'h12;
  localparam logic [7:0] op_zxt16  = 8'h13;
  localparam logic [7:0] op_sxt8   = 8'h14;
  localparam logic [7:0] op_sxt16  = 8'h15;
  localparam logic [7:0] op_sxt32  = 8'h16;
  // conditional ops are even, the inverted form is code + 1
  localparam logic [7:0] op_cmov64 = 8'h20;
  localparam logic [7:0] op_cmov32 = 8'h22;
  localparam logic [7:0] op_cset   = 8'h24;
  localparam logic [7:0] op_csand  = 8'h26;
  localparam logic [7:0] op_csor   = 8'h28;
  localparam logic [7:0] op_lahf   = 8'h30;

  localparam cond_t cond_z   = 4'd0;
  localparam cond_t cond_nz  = 4'd1;
  localparam cond_t cond_s   = 4'd2;
  localparam cond_t cond_ns  = 4'd3;
  localparam cond_t cond_ugt = 4'd4;
  localparam cond_t cond_ule = 4'd5;
  localparam cond_t cond_uge = 4'd6;
  localparam cond_t cond_ult = 4'd7;
  localparam cond_t cond_sgt = 4'd8;
  localparam cond_t cond_sle = 4'd9;
  localparam cond_t cond_sge = 4'd10;
  localparam cond_t cond_slt = 4'd11;
  localparam cond_t cond_o   = 4'd12;
  localparam cond_t cond_no  = 4'd13;
  localparam cond_t cond_p   = 4'd14;
  localparam cond_t cond_np  = 4'd15;

  function automatic op_class_t op_class(input op_word_t op, output logic [1:0] width);
    op_class_t cls;
    case (op.plain.code)
      op_add64, op_sub64, op_add32, op_sub32, op_cmp16, op_cmp8: cls = arith;
      op_and64, op_and32, op_or64, op_or32, op_xor64, op_xor32, op_xnor64, op_xnor32:
        cls = logic_op;
      op_mov64, op_mov32, op_zxt8, op_zxt16, op_sxt8, op_sxt16, op_sxt32: cls = move;
      op_lahf: cls = lahf;
      default: cls = illegal;
    endcase
    if (op.cond.code_hi inside {op_cmov64[7:1], op_cmov32[7:1], op_cset[7:1],
                                op_csand[7:1], op_csor[7:1]})
      cls = cond_op;
    case (op.plain.code)
      op_add32, op_sub32, op_and32, op_or32, op_xor32, op_xnor32, op_mov32: width = width_32;
      op_cmp16: width = width_16;
      op_cmp8: width = width_8;
      default: width = width_64;
    endcase
    if (op.cond.code_hi == op_cmov32[7:1])
      width = width_32;
    if (op.plain.reserved) begin // reserved bit kills the op
      cls = illegal;
      width = width_64;
    end
    return cls;
  endfunction

  // subtract mode of the adder, compares included
  function automatic logic op_is_sub(input op_word_t op);
    return !op.plain.reserved && (op.plain.code inside {op_sub64, op_sub32, op_cmp16, op_cmp8});
  endfunction

endpackage

`default_nettype wire

// ==== alu_stage_if.sv ====
/*
  Execute cycle bundle between the adder, the result mux and the
  retire stage. Purely combinational; everything on it is valid in the
  cycle the op is accepted and gets registered by the retire stage.
*/
`default_nettype none

interface alu_stage_if import alu_flag_pkg::*; ();

  data_t       sum;        // raw adder output
  carry_taps_t carry_taps;
  ovf_taps_t   ovf_taps;
  data_t       result;     // selected execute result

  modport arith (
    output sum,
    output carry_taps,
    output ovf_taps
  );

  modport select (
    input  sum,
    output result
  );

  modport retire (
    input result,
    input carry_taps,
    input ovf_taps
  );

endinterface

`default_nettype wire

// ==== alu_top.sv ====
/*
  One-stage pipelined 64-bit integer ALU.
  An op is taken on every rising edge with in_valid high; its result,
  flags and flags_we come out with out_valid exactly one cycle later.
  No back-pressure, so two ops can be in flight at once.
*/
`default_nettype none

module alu_top import alu_op_pkg::*, alu_flag_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  op_word_t op,
  input  data_t    a,
  input  data_t    b,
  input  flags_t   flags_in,
  output logic     out_valid,
  output data_t    result,
  output flags_t   flags_out,
  output logic     flags_we
);

  logic taken;

  alu_stage_if stage ();

  cond_eval u_cond (
    .flags (flags_in),
    .cond  ({op.cond.cond_sel, op.cond.invert}),
    .taken (taken)
  );

  add_sub_unit u_add_sub (
    .op    (op),
    .a     (a),
    .b     (b),
    .stage (stage)
  );

  logic_move_unit u_logic_move (
    .op    (op),
    .a     (a),
    .b     (b),
    .taken (taken),
    .stage (stage)
  );

  flag_gen u_flag_gen (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .op        (op),
    .a_low     (a[5:0]), // lahf source
    .stage     (stage),
    .out_valid (out_valid),
    .result    (result),
    .flags_out (flags_out),
    .flags_we  (flags_we)
  );

endmodule

`default_nettype wire

// ==== cond_eval.sv ====
/*
  Condition code evaluator.
  Tests one of the sixteen condition codes against the incoming flag
  word; the taken bit steers cmov and the conditional set ops.
*/
`default_nettype none

module cond_eval import alu_op_pkg::*, alu_flag_pkg::*; (
  input  flags_t flags,
  input  cond_t  cond,
  output logic   taken
);

  logic c;
  logic o;
  logic s;
  logic z;
  logic p;

  assign c = flags[flag_c];
  assign o = flags[flag_o];
  assign s = flags[flag_s];
  assign z = flags[flag_z];
  assign p = flags[flag_p];

  // odd codes invert the even one above them
  always_comb begin
    case (cond)
      cond_z:   taken = z;
      cond_nz:  taken = !z;
      cond_s:   taken = s;
      cond_ns:  taken = !s;
      cond_ugt: taken = c && !z;
      cond_ule: taken = !c || z;
      cond_uge: taken = c;
      cond_ult: taken = !c;
      cond_sgt: taken = (s == o) && !z;
      cond_sle: taken = (s != o) || z;
      cond_sge: taken = (s == o);
      cond_slt: taken = (s != o);
      cond_o:   taken = o;
      cond_no:  taken = !o;
      cond_p:   taken = p;
      cond_np:  taken = !p;
      default:  taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== flag_gen.sv ====
/*
  Retire stage of the ALU.
  Captures the accepted op, its result and the adder taps on the accept
  edge, then forms the flag word and the output strobes one cycle
  later. flags_we marks ops that update flags; flags_out is zero
  whenever it is low.
*/
`default_nettype none

module flag_gen import alu_op_pkg::*, alu_flag_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        in_valid,
  input  op_word_t    op,
  input  flags_t      a_low,
  alu_stage_if.retire stage,
  output logic        out_valid,
  output data_t       result,
  output flags_t      flags_out,
  output logic        flags_we
);

  logic        valid_q;
  op_word_t    op_q;
  data_t       result_q;
  flags_t      a_low_q;
  carry_taps_t carry_q;
  ovf_taps_t   ovf_q;
  op_class_t   cls;
  logic [1:0]  width;
  logic        sub;
  logic        sign;
  logic        zero;
  flags_t      f;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q  <= 1'b0;
      op_q     <= '0;
      result_q <= '0;
    end else begin
      valid_q <= in_valid;
      if (in_valid) begin
        op_q     <= op;
        result_q <= stage.result;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      a_low_q <= a_low;
      carry_q <= stage.carry_taps;
      ovf_q   <= stage.ovf_taps;
    end
  end

  always_comb begin
    cls = op_class(op_q, width);
    sub = op_is_sub(op_q);
    case (width) // sign and zero over the op width
      width_8: begin
        sign = result_q[7];
        zero = (result_q[7:0] == 8'b0);
      end
      width_16: begin
        sign = result_q[15];
        zero = (result_q[15:0] == 16'b0);
      end
      width_32: begin
        sign = result_q[31];
        zero = (result_q[31:0] == 32'b0);
      end
      default: begin
        sign = result_q[63];
        zero = (result_q == 64'b0);
      end
    endcase

    f = '0; // P is never computed
    case (cls)
      arith: begin
        f[flag_c] = carry_q[{1'b0, width} + 3'd1];
        f[flag_o] = ovf_q[width];
        f[flag_a] = carry_q[0] ^ sub; // nibble borrow on subtract
        f[flag_s] = sign;
        f[flag_z] = zero;
      end
      logic_op: begin
        f[flag_s] = sign;
        f[flag_z] = zero;
      end
      lahf:    f = a_low_q;
      default: f = '0;
    endcase

    flags_we  = valid_q && (cls inside {arith, logic_op, lahf}) && !op_q.plain.no_flags;
    flags_out = flags_we ? f : '0;
  end

  assign out_valid = valid_q;
  assign result    = result_q;

endmodule

`default_nettype wire

// ==== logic_move_unit.sv ====
/*
  Logic, move and conditional ops plus the final result mux.
  Takes the adder sum off the stage bundle, builds the bitwise, move,
  extend and conditional results and drives the selected one back.
  32-bit forms come out with the upper half cleared.
*/
`default_nettype none

module logic_move_unit import alu_op_pkg::*, alu_flag_pkg::*; (
  input  op_word_t    op,
  input  data_t       a,
  input  data_t       b,
  input  logic        taken,
  alu_stage_if.select stage
);

  op_class_t  cls;
  logic [1:0] width;
  data_t      logic_res;
  data_t      move_res;
  data_t      cond_res;
  data_t      full;

  always_comb begin
    cls = op_class(op, width);
  end

  always_comb begin
    case (op.plain.code)
      op_and64, op_and32:   logic_res = a & b;
      op_or64, op_or32:     logic_res = a | b;
      op_xor64, op_xor32:   logic_res = a ^ b;
      op_xnor64, op_xnor32: logic_res = ~(a ^ b);
      default:              logic_res = '0;
    endcase
  end

  // moves and extends all take operand b
  always_comb begin
    case (op.plain.code)
      op_mov64, op_mov32: move_res = b;
      op_zxt8:            move_res = {56'b0, b[7:0]};
      op_zxt16:           move_res = {48'b0, b[15:0]};
      op_sxt8:            move_res = {{56{b[7]}}, b[7:0]};
      op_sxt16:           move_res = {{48{b[15]}}, b[15:0]};
      op_sxt32:           move_res = {{32{b[31]}}, b[31:0]};
      default:            move_res = '0;
    endcase
  end

  // inverted forms only flip the condition, decoded upstream
  always_comb begin
    case (op.cond.code_hi)
      op_cmov64[7:1], op_cmov32[7:1]: cond_res = taken ? b : a;
      op_cset[7:1]:                   cond_res = {63'b0, taken};
      op_csand[7:1]:                  cond_res = {63'b0, taken & a[0]};
      op_csor[7:1]:                   cond_res = {63'b0, taken | a[0]};
      default:                        cond_res = '0;
    endcase
  end

  always_comb begin
    case (cls)
      arith:    full = stage.sum; // compares keep the whole difference
      logic_op: full = logic_res;
      move:     full = move_res;
      cond_op:  full = cond_res;
      default:  full = '0; // lahf, illegal
    endcase
    if (width == width_32)
      stage.result = {32'b0, full[31:0]};
    else
      stage.result = full;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
alu_flag_pkg.sv
alu_op_pkg.sv
alu_stage_if.sv
cond_eval.sv
add_sub_unit.sv
logic_move_unit.sv
flag_gen.sv
alu_top.sv
tb_alu.sv

// ==== tb_alu_model.svh ====
/*
  Reference model for the ALU testbench.
  Gives the expected result, flag word and flags_we of one operation
  from the instruction rules. Included inside tb_alu, which imports
  both ALU packages.
*/
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

function automatic data_t width_mask(input int w);
  return (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
endfunction

function automatic logic top_bit(input data_t v, input int w);
  data_t t;
  t = v >> (w - 1);
  return t[0];
endfunction

// even code tests, odd code negates
function automatic logic cond_holds(input flags_t f, input logic [3:0] cc);
  logic hit;
  case (cc[3:1])
    3'd0: hit = f[flag_z];
    3'd1: hit = f[flag_s];
    3'd2: hit = f[flag_c] & ~f[flag_z];
    3'd3: hit = f[flag_c];
    3'd4: hit = (f[flag_s] ~^ f[flag_o]) & ~f[flag_z];
    3'd5: hit = f[flag_s] ~^ f[flag_o];
    3'd6: hit = f[flag_o];
    default: hit = f[flag_p];
  endcase
  return hit ^ cc[0];
endfunction

function automatic void model_op(input op_word_t opw, input data_t x, input data_t y,
                                 input flags_t fin, output data_t r, output flags_t f,
                                 output logic we);
  logic [7:0]  code;
  logic        sub;
  logic        hit;
  logic        upd;
  logic        sa;
  logic        sb;
  int          w;
  data_t       mask;
  data_t       yy;
  logic [64:0] total;
  logic [64:0] tmp;
  logic [4:0]  nib;
  code = opw.plain.code;
  hit  = cond_holds(fin, {opw.plain.modifier, code[0]});
  w    = 64;
  if (code inside {op_add32, op_sub32, op_and32, op_or32, op_xor32, op_xnor32, op_mov32,
                   op_cmov32, op_cmov32 + 8'd1})
    w = 32;
  if (code == op_cmp16) w = 16;
  if (code == op_cmp8) w = 8;
  mask = width_mask(w);
  r    = '0;
  f    = '0;
  upd  = 1'b0;
  sub  = code inside {op_sub64, op_sub32, op_cmp16, op_cmp8};
  yy   = sub ? ~y : y;
  if (code inside {[op_add64:op_cmp8]}) begin
    r     = x + yy + {63'b0, sub};
    total = {1'b0, x & mask} + {1'b0, yy & mask} + {64'b0, sub};
    tmp   = total >> w; // carry out of the top bit
    nib   = {1'b0, x[3:0]} + {1'b0, yy[3:0]} + {4'b0, sub};
    sa    = top_bit(x, w);
    sb    = top_bit(y, w);
    f[flag_c] = tmp[0];
    f[flag_o] = (sub ? (sa != sb) : (sa == sb)) && (top_bit(r, w) != sa);
    f[flag_a] = nib[4] ^ sub;
    upd = 1'b1;
  end else if (code inside {[op_and64:op_xnor32]}) begin
    case (code)
      op_and64, op_and32: r = x & y;
      op_or64, op_or32:   r = x | y;
      op_xor64, op_xor32: r = x ^ y;
      default:            r = ~(x ^ y);
    endcase
    upd = 1'b1;
  end else if (code inside {[op_mov64:op_sxt32]}) begin
    case (code)
      op_zxt8:  r = y & 64'hff;
      op_zxt16: r = y & 64'hffff;
      op_sxt8:  r = y[7] ? (y | ~64'hff) : (y & 64'hff);
      op_sxt16: r = y[15] ? (y | ~64'hffff) : (y & 64'hffff);
      op_sxt32: r = y[31] ? (y | ~64'hffff_ffff) : (y & 64'hffff_ffff);
      default:  r = y;
    endcase
  end else if (code inside {[op_cmov64:op_csor + 8'd1]}) begin
    case ({code[7:1], 1'b0})
      op_cset:  r = {63'b0, hit};
      op_csand: r = {63'b0, hit & x[0]};
      op_csor:  r = {63'b0, hit | x[0]};
      default:  r = hit ? y : x; // both cmov widths
    endcase
  end else if (code == op_lahf) begin
    f   = x[5:0];
    upd = 1'b1;
  end
  if (w == 32) r = r & mask;
  if (upd && code != op_lahf) begin
    f[flag_s] = top_bit(r, w);
    f[flag_z] = ((r & mask) == '0);
  end
  we = upd && !opw.plain.no_flags;
  if (!we) f = '0;
endfunction

`endif

// ==== tb_alu.sv ====
/*
  Testbench for the pipelined integer ALU.
  Directed arithmetic, logic, move, flag and condition cases come first,
  then random ops with idle gaps. Each accepted op is queued with its
  expected outputs and checked in the cycle its out_valid shows up.
*/
`default_nettype none

module tb_alu import alu_op_pkg::*, alu_flag_pkg::*; ();

  localparam int cycle_limit = 1000; // about 640 cycles of stimulus plus margin

  logic     clk = 1'b0;
  logic     rst;
  logic     in_valid;
  op_word_t op;
  data_t    a;
  data_t    b;
  flags_t   flags_in;
  logic     out_valid;
  data_t    result;
  flags_t   flags_out;
  logic     flags_we;

  int         seed = 75407;
  int         cycles = 0;
  int         issued = 0;
  int         checks = 0;
  int         value_errors = 0;
  int         timing_errors = 0;
  logic       accepted = 1'b0;
  logic       rst_at_edge = 1'b1;
  data_t      exp_result_q[$];
  flags_t     exp_flags_q[$];
  logic       exp_we_q[$];
  logic [7:0] op_list [27];

  `include "tb_alu_model.svh"

  alu_top u_alu_top (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .op        (op),
    .a         (a),
    .b         (b),
    .flags_in  (flags_in),
    .out_valid (out_valid),
    .result    (result),
    .flags_out (flags_out),
    .flags_we  (flags_we)
  );

  always #5 clk = ~clk;

  function automatic data_t rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic flags_t rand_flags();
    int r;
    r = $random(seed);
    return r[5:0];
  endfunction

  task automatic send_op(input logic nf, input logic [2:0] mod, input logic [7:0] code,
                         input data_t x, input data_t y, input flags_t f);
    in_valid = 1'b1;
    op       = {nf, 1'b0, mod, code};
    a        = x;
    b        = y;
    flags_in = f;
    issued++;
    @(posedge clk);
    #1;
  endtask

  task automatic idle_cycle();
    in_valid = 1'b0;
    a        = rand64(); // must be ignored
    @(posedge clk);
    #1;
  endtask

  task automatic report_mismatch(input string name, input data_t exp, input data_t got);
    value_errors++;
    $display("Fail t=%0t %s expected %h got %h", $time, name, exp, got);
  endtask

  always @(posedge clk) begin : record_ops
    data_t  er;
    flags_t ef;
    logic   ew;
    rst_at_edge = rst;
    accepted    = !rst && in_valid;
    if (accepted) begin
      model_op(op, a, b, flags_in, er, ef, ew);
      exp_result_q.push_back(er);
      exp_flags_q.push_back(ef);
      exp_we_q.push_back(ew);
    end
  end

  // outputs are settled half a cycle after the edge
  always @(negedge clk) begin : check_outputs
    data_t  er;
    flags_t ef;
    logic   ew;
    if (rst_at_edge) begin
      assert (out_valid === 1'b0 && flags_we === 1'b0 && result === '0 && flags_out === '0)
      else begin
        timing_errors++;
        $display("outputs not cleared while reset is held, t=%0t", $time);
      end
    end else begin
      assert (out_valid === accepted) else begin
        timing_errors++;
        $display("Fail t=%0t out_valid expected %b got %b", $time, accepted, out_valid);
      end
      if (accepted && exp_result_q.size() > 0) begin
        er = exp_result_q.pop_front();
        ef = exp_flags_q.pop_front();
        ew = exp_we_q.pop_front();
        checks++;
        assert (result === er) else report_mismatch("result", er, result);
        assert (flags_out === ef) else report_mismatch("flags_out", 64'(ef), 64'(flags_out));
        assert (flags_we === ew) else report_mismatch("flags_we", 64'(ew), 64'(flags_we));
      end else begin
        assert (flags_we === 1'b0) else report_mismatch("flags_we", 64'd0, 64'(flags_we));
      end
    end
  end

  valid_after_accept: assert property (@(posedge clk) disable iff (rst) in_valid |=> out_valid)
    else begin
      timing_errors++;
      $display("out_valid missing one cycle after an accepted op, t=%0t", $time);
    end

  no_stray_valid: assert property (@(posedge clk) disable iff (rst) !in_valid |=> !out_valid)
    else begin
      timing_errors++;
      $display("out_valid high without an accepted op, t=%0t", $time);
    end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the run did not complete", cycle_limit);
      $display("checks %0d, value errors %0d, timing errors %0d",
               checks, value_errors, timing_errors);
      $display("Test failed");
      $finish;
    end
  end

  initial begin : stimulus
    int         rnd;
    int         sent;
    logic [7:0] code;
    op_list = '{op_add64, op_sub64, op_add32, op_sub32, op_cmp16, op_cmp8,
                op_and64, op_and32, op_or64, op_or32, op_xor64, op_xor32,
                op_xnor64, op_xnor32, op_mov64, op_mov32, op_zxt8, op_zxt16,
                op_sxt8, op_sxt16, op_sxt32, op_cmov64, op_cmov32, op_cset,
                op_csand, op_csor, op_lahf};
    rst      = 1'b1;
    in_valid = 1'b0;
    op       = '0;
    a        = '0;
    b        = '0;
    flags_in = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    // back-to-back overflow, carry and zero cases
    send_op(1'b0, 3'd0, op_add64, 64'h7fff_ffff_ffff_ffff, 64'd1, 6'd0);
    send_op(1'b0, 3'd0, op_add64, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 6'd0);
    send_op(1'b0, 3'd0, op_add64, '1, 64'd1, 6'd0);
    send_op(1'b0, 3'd0, op_sub64, 64'h8000_0000_0000_0000, 64'd1, 6'd0);
    send_op(1'b0, 3'd0, op_sub64, 64'd42, 64'd42, 6'd0);
    send_op(1'b0, 3'd0, op_add32, 64'hdead_beef_7fff_ffff, 64'd1, 6'd0);
    send_op(1'b0, 3'd0, op_sub32, 64'h1234_5678_0000_0000, 64'd1, 6'd0);
    send_op(1'b0, 3'd0, op_cmp16, 64'h8000, 64'd1, 6'd0);
    send_op(1'b0, 3'd0, op_cmp16, 64'h7fff, 64'hffff, 6'd0);
    send_op(1'b0, 3'd0, op_cmp8, 64'h80, 64'd1, 6'd0);
    send_op(1'b0, 3'd0, op_cmp8, 64'h5a, 64'h5a, 6'd0);

    // logic, moves and extends
    send_op(1'b0, 3'd0, op_and64, 64'hf0f0, 64'h0f0f, 6'd0);
    send_op(1'b0, 3'd0, op_or32, 64'hffff_0000_8000_0000, 64'h1, 6'd0);
    send_op(1'b0, 3'd0, op_xor64, 64'h0123_4567_89ab_cdef, 64'h0123_4567_89ab_cdef, 6'd0);
    send_op(1'b0, 3'd0, op_xnor32, 64'h5555_5555_5555_5555, 64'haaaa_aaaa_aaaa_aaaa, 6'd0);
    send_op(1'b0, 3'd5, op_mov64, 64'd0, 64'hfedc_ba98_7654_3210, 6'd0);
    send_op(1'b0, 3'd0, op_mov32, 64'd0, 64'hfedc_ba98_7654_3210, 6'd0);
    send_op(1'b0, 3'd0, op_zxt8, 64'd0, '1, 6'd0);
    send_op(1'b0, 3'd0, op_zxt16, 64'd0, '1, 6'd0);
    send_op(1'b0, 3'd0, op_sxt8, 64'd0, 64'h80, 6'd0);
    send_op(1'b0, 3'd0, op_sxt16, 64'd0, 64'h1234_8000, 6'd0);
    send_op(1'b0, 3'd0, op_sxt32, 64'd0, 64'h8000_0000, 6'd0);

    // no_flags suppresses the flag write
    send_op(1'b1, 3'd0, op_add64, 64'd5, 64'd7, 6'd0);
    send_op(1'b1, 3'd0, op_xor32, 64'd3, 64'd3, 6'd0);
    // lahf loads a[5:0]
    send_op(1'b0, 3'd0, op_lahf, 64'hffff_ff2b, 64'd0, 6'd0);
    send_op(1'b1, 3'd0, op_lahf, 64'h3f, 64'd0, 6'd0);
    send_op(1'b0, 3'd0, 8'h3f, 64'd1, 64'd2, 6'd0); // unused code decodes as illegal

    for (int cc = 0; cc < 16; cc++) begin
      send_op(1'b0, cc[3:1], op_cmov64 | {7'b0, cc[0]}, rand64(), rand64(), rand_flags());
      send_op(1'b0, cc[3:1], op_cset | {7'b0, cc[0]}, rand64(), rand64(), rand_flags());
      send_op(1'b0, cc[3:1], op_csand | {7'b0, cc[0]}, rand64(), rand64(), rand_flags());
      send_op(1'b0, cc[3:1], op_csor | {7'b0, cc[0]}, rand64(), rand64(), rand_flags());
    end

    // reset with an op still in flight
    send_op(1'b0, 3'd0, op_sub64, 64'd0, 64'd1, 6'd0);
    rst = 1'b1; // in_valid stays high and is dropped
    repeat (2) @(posedge clk);
    #1;
    rst      = 1'b0;
    in_valid = 1'b0;

    // random ops with an idle cycle about one time in four
    sent = 0;
    while (sent < 400) begin
      rnd = $random(seed);
      if (rnd[1:0] == 2'b00) begin
        idle_cycle();
      end else begin
        code = op_list[5'(($unsigned(rnd) >> 8) % 27)];
        if (code inside {[op_cmov64:op_csor]})
          code[0] = rnd[30]; // inverted form
        send_op(rnd[4:2] == 3'b000, rnd[7:5], code, rand64(), rand64(), rand_flags());
        sent++;
      end
    end

    idle_cycle();
    while (exp_result_q.size() != 0) @(negedge clk);
    @(negedge clk);
    if (checks != issued) begin
      timing_errors++;
      $display("%0d ops were issued but only %0d were checked", issued, checks);
    end
    $display("checks %0d, value errors %0d, timing errors %0d",
             checks, value_errors, timing_errors);
    if (value_errors == 0 && timing_errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
